//--- instr_pkg.sv
`default_nettype none

package instr_pkg;

   localparam int XLEN     = 32;
   localparam int ROB_ID_W = 5;
   localparam int UOP_OP_W = 8;

   typedef logic [ROB_ID_W-1:0] t_rob_id;
   typedef logic [XLEN-1:0]     t_rv_reg_data;
   typedef logic [UOP_OP_W-1:0] t_uop_op; // opaque to the station.

   // micro-op as it leaves rename.
   typedef struct packed {
      t_uop_op      op;
      t_rob_id      dst_robid;
      logic         src1_pdg;   // waiting on src1_robid.
      t_rob_id      src1_robid;
      t_rv_reg_data src1_data;  // regfile read, only good when not pending.
      logic         src2_pdg;
      t_rob_id      src2_robid;
      t_rv_reg_data src2_data;
   } t_uop_disp;

   // writeback broadcast, strobe travels beside it.
   typedef struct packed {
      t_rob_id      robid;
      t_rv_reg_data result;
   } t_wb;

   // what execute gets.
   typedef struct packed {
      t_uop_op      op;
      t_rob_id      dst_robid;
      t_rv_reg_data src1_data;
      t_rv_reg_data src2_data;
   } t_rs_issue;

endpackage

`default_nettype wire

//--- rs_entry.sv
`timescale 1ns/1ps
`default_nettype none

module rs_entry
   import instr_pkg::*, rs_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      alloc_en,
   input  t_uop_disp alloc,

   input  logic      wb_valid,
   input  t_wb       wb,

   input  logic      release_en,

   output logic      valid,
   output logic      ready,
   output t_rs_issue iss
);

t_uop_op                op;
t_rob_id                dst_robid;
t_rs_src_alloc          src_alloc [NUM_SOURCES];
t_rv_reg_data           src_data  [NUM_SOURCES];
logic [NUM_SOURCES-1:0] src_ready;

always_ff @(posedge clk) begin
   if (!rst_n) begin
      valid <= 1'b0;
   end else if (alloc_en) begin
      valid <= 1'b1;
   end else if (release_en) begin
      valid <= 1'b0; // issued this cycle.
   end
end

always_ff @(posedge clk) begin
   if (alloc_en) begin
      op        <= alloc.op;
      dst_robid <= alloc.dst_robid;
   end
end

// split the dispatch packet per source.
assign src_alloc[0] = '{from_rob: alloc.src1_pdg, robid: alloc.src1_robid,
                        data: alloc.src1_data};
assign src_alloc[1] = '{from_rob: alloc.src2_pdg, robid: alloc.src2_robid,
                        data: alloc.src2_data};

for (genvar srcx = 0; srcx < NUM_SOURCES; srcx++) begin : g_src_trk
   rs_src_trk i_src_trk (
      .clk       (clk),
      .rst_n     (rst_n),
      .alloc_en  (alloc_en),
      .src_alloc (src_alloc[srcx]),
      .wb_valid  (wb_valid),
      .wb        (wb),
      .ready     (src_ready[srcx]),
      .src_data  (src_data[srcx])
   );
end

assign ready = valid && (&src_ready);
assign iss   = '{op: op, dst_robid: dst_robid,
                 src1_data: src_data[0], src2_data: src_data[1]};

// steering in the top picks free entries only.
a_alloc_on_free: assert property (
   @(posedge clk) disable iff (!rst_n) alloc_en |-> !valid
);

a_release_when_ready: assert property (
   @(posedge clk) disable iff (!rst_n) release_en |-> ready
);

endmodule

`default_nettype wire

//--- rs_issue_sel.sv
`timescale 1ns/1ps
`default_nettype none

module rs_issue_sel
   import instr_pkg::*, rs_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,

   input  logic [NUM_RS_ENTRIES-1:0] ready,
   input  t_rs_issue                 ent_iss [NUM_RS_ENTRIES],

   output logic [NUM_RS_ENTRIES-1:0] release_oh,
   output logic                      iss_valid,
   output t_rs_issue                 iss
);

t_rs_idx sel_idx;
logic    any_ready;

// lowest index wins.
always_comb begin
   sel_idx = '0;
   for (int i = NUM_RS_ENTRIES - 1; i >= 0; i--) begin
      if (ready[i]) begin
         sel_idx = t_rs_idx'(i);
      end
   end
end

assign any_ready = |ready;

always_comb begin
   release_oh          = '0;
   release_oh[sel_idx] = any_ready; // frees the entry at the issue edge.
end

always_ff @(posedge clk) begin
   if (!rst_n) begin
      iss_valid <= 1'b0;
   end else begin
      iss_valid <= any_ready;
   end
end

always_ff @(posedge clk) begin
   if (any_ready) begin
      iss <= ent_iss[sel_idx];
   end
end

// lowest set bit of ready, or nothing.
a_release_lowest: assert property (
   @(posedge clk) disable iff (!rst_n)
   release_oh == (ready & (~ready + NUM_RS_ENTRIES'(1)))
);

endmodule

`default_nettype wire

//--- rs_pkg.sv
`default_nettype none

package rs_pkg;

   import instr_pkg::*;

   localparam int NUM_RS_ENTRIES = 4;
   localparam int NUM_SOURCES    = 2;
   localparam int RS_IDX_W       = $clog2(NUM_RS_ENTRIES);

   typedef logic [RS_IDX_W-1:0] t_rs_idx;

   // one source as seen by its tracker at allocation.
   typedef struct packed {
      logic         from_rob; // result still in flight.
      t_rob_id      robid;
      t_rv_reg_data data;
   } t_rs_src_alloc;

endpackage

`default_nettype wire

//--- rs_src_trk.sv
`timescale 1ns/1ps
`default_nettype none

module rs_src_trk
   import instr_pkg::*, rs_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   input  logic          alloc_en,
   input  t_rs_src_alloc src_alloc,

   input  logic          wb_valid,
   input  t_wb           wb,

   output logic          ready,
   output t_rv_reg_data  src_data
);

logic         pending;
t_rob_id      robid;
t_rv_reg_data data;
logic         alloc_hit;
logic         wb_hit;

// result showing up in the very cycle the source is allocated.
assign alloc_hit = wb_valid && src_alloc.from_rob && (wb.robid == src_alloc.robid);
assign wb_hit    = wb_valid && pending && (wb.robid == robid);

always_ff @(posedge clk) begin
   if (!rst_n) begin
      pending <= 1'b0;
   end else if (alloc_en) begin
      pending <= src_alloc.from_rob && !alloc_hit;
   end else if (wb_hit) begin
      pending <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (alloc_en) begin
      robid <= src_alloc.robid;
      data  <= alloc_hit ? wb.result : src_alloc.data;
   end else if (wb_hit) begin
      data  <= wb.result; // wakeup.
   end
end

assign ready    = !pending;
assign src_data = data;

endmodule

`default_nettype wire

//--- rs_station.sv
`timescale 1ns/1ps
`default_nettype none

module rs_station
   import instr_pkg::*, rs_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      alloc_valid,
   input  t_uop_disp alloc,

   input  logic      wb_valid,
   input  t_wb       wb,

   output logic      iss_valid,
   output t_rs_issue iss,

   output logic      rs_full
);

logic [NUM_RS_ENTRIES-1:0] ent_valid;
logic [NUM_RS_ENTRIES-1:0] ent_ready;
logic [NUM_RS_ENTRIES-1:0] free_oh;
logic [NUM_RS_ENTRIES-1:0] alloc_en;
logic [NUM_RS_ENTRIES-1:0] release_oh;
t_rs_issue                 ent_iss [NUM_RS_ENTRIES];

// lowest clear bit of the valids, zero when full.
assign free_oh  = ~ent_valid & (ent_valid + NUM_RS_ENTRIES'(1));
assign alloc_en = free_oh & {NUM_RS_ENTRIES{alloc_valid}};
assign rs_full  = &ent_valid;

for (genvar entx = 0; entx < NUM_RS_ENTRIES; entx++) begin : g_entry
   rs_entry i_entry (
      .clk        (clk),
      .rst_n      (rst_n),
      .alloc_en   (alloc_en[entx]),
      .alloc      (alloc),
      .wb_valid   (wb_valid),
      .wb         (wb),
      .release_en (release_oh[entx]),
      .valid      (ent_valid[entx]),
      .ready      (ent_ready[entx]),
      .iss        (ent_iss[entx])
   );
end

rs_issue_sel i_issue_sel (
   .clk        (clk),
   .rst_n      (rst_n),
   .ready      (ent_ready),
   .ent_iss    (ent_iss),
   .release_oh (release_oh),
   .iss_valid  (iss_valid),
   .iss        (iss)
);

// dispatch has to hold off on full, there is no stall back.
a_no_alloc_when_full: assert property (
   @(posedge clk) disable iff (!rst_n) alloc_valid |-> !rs_full
);

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
instr_pkg.sv
rs_pkg.sv
rs_src_trk.sv
rs_entry.sv
rs_issue_sel.sv
rs_station.sv
tb_rs_station.sv

//--- tb_rs_checks.svh
`ifndef TB_RS_CHECKS_SVH
`define TB_RS_CHECKS_SVH

// galois form, shifting right.
function automatic logic [31:0] next_lfsr(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step for every bit handed out.
function automatic logic [31:0] take_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

function automatic t_uop_disp random_uop(input logic p1, input t_rob_id r1,
                                         input logic p2, input t_rob_id r2);
   t_uop_disp u;
   u.op         = t_uop_op'(take_bits(UOP_OP_W));
   u.dst_robid  = t_rob_id'(take_bits(ROB_ID_W));
   u.src1_pdg   = p1;
   u.src1_robid = r1;
   u.src1_data  = take_bits(XLEN); // junk when pending.
   u.src2_pdg   = p2;
   u.src2_robid = r2;
   u.src2_data  = take_bits(XLEN);
   return u;
endfunction

// pending sources end up with the writeback result.
function automatic t_rs_issue expected_issue(input t_uop_disp u, input t_rv_reg_data res1,
                                             input t_rv_reg_data res2);
   t_rs_issue e;
   e.op        = u.op;
   e.dst_robid = u.dst_robid;
   e.src1_data = u.src1_pdg ? res1 : u.src1_data;
   e.src2_data = u.src2_pdg ? res2 : u.src2_data;
   return e;
endfunction

task automatic drive(input logic av, input t_uop_disp a, input logic wv, input t_wb w,
                     output int unsigned stamp);
   @(posedge clk);
   alloc_valid <= av;
   alloc       <= a;
   wb_valid    <= wv;
   wb          <= w;
   stamp = cycle + 1; // the cycle this edge opens.
endtask

task automatic idle(input int n);
   int unsigned stamp;
   repeat (n) drive(1'b0, '0, 1'b0, '0, stamp);
endtask

task automatic check_issue(input string name, input t_rs_issue exp, input t_rs_issue act);
   chk_cnt++;
   if (act !== exp) begin
      $display("[FAIL] %s: expected op=%h dst=%h s1=%h s2=%h, actual op=%h dst=%h s1=%h s2=%h",
               name, exp.op, exp.dst_robid, exp.src1_data, exp.src2_data,
               act.op, act.dst_robid, act.src1_data, act.src2_data);
      err_cnt++;
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   chk_cnt++;
   if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      err_cnt++;
   end
endtask

// a few idle cycles in which nothing may issue.
task automatic quiet(input string name, input int n);
   repeat (n) begin
      idle(1);
      @(negedge clk);
      check_flag(name, 1'b0, iss_valid);
   end
endtask

task automatic expect_issue(input string name, input t_rs_issue exp,
                            input int unsigned stamp, input int unsigned lat);
   t_rs_issue   got;
   int unsigned at;
   int unsigned n;
   n = 0;
   while (iss_q.size() == 0 && n < ISSUE_WAIT) begin
      @(negedge clk);
      n++;
   end
   if (iss_q.size() == 0) begin
      $display("%s: nothing was issued within %0d cycles", name, ISSUE_WAIT);
      err_cnt++;
   end else begin
      got = iss_q.pop_front();
      at  = iss_cyc_q.pop_front();
      check_issue(name, exp, got);
      if (at - stamp != lat) begin
         $display("[FAIL] %s: latency expected %0d, actual %0d", name, lat, at - stamp);
         err_cnt++;
      end
   end
endtask

task automatic end_test(input string name, input int unsigned errs_before);
   idle(3);
   if (iss_q.size() != 0) begin
      $display("%s: %0d issues came out that were not expected", name, iss_q.size());
      err_cnt++;
      iss_q.delete();
      iss_cyc_q.delete();
   end
   tests_run++;
   if (err_cnt == errs_before) begin
      $display("test %-14s ok", name);
   end else begin
      tests_bad++;
      $display("test %-14s %0d errors", name, err_cnt - errs_before);
   end
endtask

`endif

//--- tb_rs_station.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rs_station
   import instr_pkg::*, rs_pkg::*;
();

localparam int unsigned TIMEOUT_CYCLES = 400; // tests need about 130 cycles.
localparam int unsigned ISSUE_WAIT     = 12;
localparam logic [31:0] LFSR_SEED      = 32'h955d_a62a;

logic      clk;
logic      rst_n;
logic      alloc_valid;
t_uop_disp alloc;
logic      wb_valid;
t_wb       wb;
logic      iss_valid;
t_rs_issue iss;
logic      rs_full;

logic [31:0] lfsr_state;
int unsigned cycle;
int unsigned err_cnt;
int unsigned chk_cnt;
int unsigned tests_run;
int unsigned tests_bad;
t_rs_issue   iss_q [$];
int unsigned iss_cyc_q [$];

`include "tb_rs_checks.svh"

rs_station i_dut (
   .clk         (clk),
   .rst_n       (rst_n),
   .alloc_valid (alloc_valid),
   .alloc       (alloc),
   .wb_valid    (wb_valid),
   .wb          (wb),
   .iss_valid   (iss_valid),
   .iss         (iss),
   .rs_full     (rs_full)
);

always #4 clk = ~clk;

always @(posedge clk) begin
   cycle <= cycle + 1;
   if (cycle >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles, the tests did not complete", cycle);
      $display("Simulation finished: FAIL");
      $finish;
   end
end

// issue monitor, with the cycle each packet shows up in.
always @(negedge clk) begin
   if (rst_n && iss_valid) begin
      iss_q.push_back(iss);
      iss_cyc_q.push_back(cycle);
   end
end

task automatic test_reset_issue();
   t_uop_disp   u;
   int unsigned t0;
   int unsigned errs;
   errs = err_cnt;
   @(negedge clk);
   check_flag("reset iss_valid", 1'b0, iss_valid);
   check_flag("reset rs_full", 1'b0, rs_full);
   u = random_uop(1'b0, '0, 1'b0, '0);
   drive(1'b1, u, 1'b0, '0, t0);
   idle(1);
   expect_issue("ready dispatch", expected_issue(u, '0, '0), t0, 2);
   end_test("reset_issue", errs);
endtask

task automatic test_wakeup();
   t_uop_disp    u;
   t_rob_id      r;
   t_rv_reg_data res;
   int unsigned  t0;
   int unsigned  errs;
   errs = err_cnt;
   r    = t_rob_id'(take_bits(ROB_ID_W));
   res  = take_bits(XLEN);
   u    = random_uop(1'b1, r, 1'b0, '0);
   drive(1'b1, u, 1'b0, '0, t0);
   quiet("wakeup pending", 4);
   drive(1'b0, '0, 1'b1, '{robid: r ^ 5'd9, result: ~res}, t0); // wrong id.
   quiet("wakeup other id", 4);
   drive(1'b0, '0, 1'b1, '{robid: r, result: res}, t0);
   idle(1);
   expect_issue("wakeup match", expected_issue(u, res, '0), t0, 2);
   end_test("wakeup", errs);
endtask

task automatic test_alloc_capture();
   t_uop_disp    u;
   t_rob_id      r;
   t_rv_reg_data res;
   int unsigned  t0;
   int unsigned  errs;
   errs = err_cnt;
   r    = t_rob_id'(take_bits(ROB_ID_W));
   res  = take_bits(XLEN);
   u    = random_uop(1'b0, '0, 1'b1, r);
   drive(1'b1, u, 1'b1, '{robid: r, result: res}, t0);
   idle(1);
   expect_issue("alloc-cycle wb", expected_issue(u, '0, res), t0, 2);
   end_test("alloc_capture", errs);
endtask

task automatic test_full_order();
   t_uop_disp    u [NUM_RS_ENTRIES];
   t_rv_reg_data res [NUM_RS_ENTRIES];
   int unsigned  t_wake [NUM_RS_ENTRIES];
   t_rob_id      base;
   int unsigned  t0;
   int unsigned  errs;
   errs = err_cnt;
   base = t_rob_id'(take_bits(ROB_ID_W));
   for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
      u[i]   = random_uop(1'b1, base + t_rob_id'(i), 1'b0, '0);
      res[i] = take_bits(XLEN);
      drive(1'b1, u[i], 1'b0, '0, t0);
   end
   idle(1);
   @(negedge clk);
   check_flag("full after four", 1'b1, rs_full);
   for (int i = NUM_RS_ENTRIES - 1; i >= 0; i--) begin
      drive(1'b0, '0, 1'b1, '{robid: base + t_rob_id'(i), result: res[i]}, t_wake[i]);
   end
   idle(1);
   for (int i = NUM_RS_ENTRIES - 1; i >= 0; i--) begin
      expect_issue("reverse wake", expected_issue(u[i], res[i], '0), t_wake[i], 2);
   end
   // all on one robid.
   base   = t_rob_id'(take_bits(ROB_ID_W));
   res[0] = take_bits(XLEN);
   for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
      u[i] = random_uop(1'b0, '0, 1'b1, base);
      drive(1'b1, u[i], 1'b0, '0, t0);
   end
   idle(1);
   @(negedge clk);
   check_flag("full again", 1'b1, rs_full);
   drive(1'b0, '0, 1'b1, '{robid: base, result: res[0]}, t0);
   idle(1);
   for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
      expect_issue("one wb order", expected_issue(u[i], '0, res[0]), t0, 2 + i);
   end
   end_test("full_order", errs);
endtask

task automatic test_reuse();
   t_uop_disp    u [NUM_RS_ENTRIES];
   t_rv_reg_data res [NUM_RS_ENTRIES];
   int unsigned  t_wake [NUM_RS_ENTRIES];
   t_uop_disp    ua;
   t_uop_disp    ub;
   t_rv_reg_data rb;
   t_rob_id      base;
   int unsigned  ta;
   int unsigned  t0;
   int unsigned  errs;
   errs = err_cnt;
   base = t_rob_id'(take_bits(ROB_ID_W));
   for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
      u[i]   = random_uop(1'b1, base + t_rob_id'(i), 1'b0, '0);
      res[i] = take_bits(XLEN);
      drive(1'b1, u[i], 1'b0, '0, t0);
   end
   idle(1);
   @(negedge clk);
   check_flag("reuse full", 1'b1, rs_full);
   drive(1'b0, '0, 1'b1, '{robid: base + 5'd1, result: res[1]}, t_wake[1]);
   drive(1'b0, '0, 1'b1, '{robid: base + 5'd2, result: res[2]}, t_wake[2]);
   idle(1);
   expect_issue("reuse drain 1", expected_issue(u[1], res[1], '0), t_wake[1], 2);
   expect_issue("reuse drain 2", expected_issue(u[2], res[2], '0), t_wake[2], 2);
   check_flag("full drops", 1'b0, rs_full);
   // entries 1 and 2 again, with fresh operands.
   rb = take_bits(XLEN);
   ub = random_uop(1'b1, base + 5'd4, 1'b0, '0);
   ua = random_uop(1'b0, '0, 1'b0, '0);
   drive(1'b1, ub, 1'b0, '0, t0);
   drive(1'b1, ua, 1'b0, '0, ta);
   idle(1);
   @(negedge clk);
   check_flag("reuse refilled", 1'b1, rs_full);
   expect_issue("reuse fresh", expected_issue(ua, '0, '0), ta, 2);
   drive(1'b0, '0, 1'b1, '{robid: base + 5'd4, result: rb}, t0);
   idle(1);
   expect_issue("reuse pending", expected_issue(ub, rb, '0), t0, 2);
   drive(1'b0, '0, 1'b1, '{robid: base, result: res[0]}, t_wake[0]);
   drive(1'b0, '0, 1'b1, '{robid: base + 5'd3, result: res[3]}, t_wake[3]);
   idle(1);
   expect_issue("reuse old 0", expected_issue(u[0], res[0], '0), t_wake[0], 2);
   expect_issue("reuse old 3", expected_issue(u[3], res[3], '0), t_wake[3], 2);
   check_flag("empty at end", 1'b0, rs_full);
   end_test("reuse", errs);
endtask

initial begin
   clk         = 1'b0;
   rst_n       = 1'b0;
   alloc_valid = 1'b0;
   alloc       = '0;
   wb_valid    = 1'b0;
   wb          = '0;
   lfsr_state  = LFSR_SEED;
   cycle       = 0;
   err_cnt     = 0;
   chk_cnt     = 0;
   tests_run   = 0;
   tests_bad   = 0;
   repeat (4) @(posedge clk);
   rst_n <= 1'b1;
   test_reset_issue();
   test_wakeup();
   test_alloc_capture();
   test_full_order();
   test_reuse();
   $display("%0d tests, %0d failed, %0d checks, %0d errors",
            tests_run, tests_bad, chk_cnt, err_cnt);
   if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
   end else begin
      $display("Simulation finished: FAIL");
   end
   $finish;
end

endmodule

`default_nettype wire
